// File: thumb_core.f
source/thumb_pkg.sv
source/fetch_unit.sv
source/decode_stage.sv
source/reg_file.sv
source/execute_stage.sv
source/store_port.sv
source/thumb_core.sv
verification/thumb_checker.sv
verification/tb_thumb_core.sv

// File: Makefile
VERILATOR  ?= verilator
TB_TOP     ?= tb_thumb_core
RTL_TOP    ?= thumb_core
FILELIST   ?= thumb_core.f
BUILD_DIR  ?= obj_dir
SIM_FLAGS  ?= --binary --timing
LINT_FLAGS ?= --lint-only
PASS_TEXT  ?= Simulation PASSED

RTL_SRCS ?= source/thumb_pkg.sv \
	source/fetch_unit.sv \
	source/decode_stage.sv \
	source/reg_file.sv \
	source/execute_stage.sv \
	source/store_port.sv \
	source/thumb_core.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: verification/tb_thumb_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_thumb_core import thumb_pkg::*; ();

	localparam int    PROG_LEN = 200;
	localparam int    CLK_PERIOD = 4;
	localparam int    RESET_CYCLES = 8;
	localparam int    PIPE_LATENCY = 4;
	localparam word_t PC_BASE = 32'h0000_0200;
	localparam word_t PROG_END = PC_BASE + word_t'(2 * PROG_LEN);

	logic CLK;
	logic RESET_N;
	logic IREQ;
	word_t IADDR;
	logic IRW;
	word_t INSTR;
	logic DREQ;
	word_t DADDR;
	logic DRW;
	logic [1:0] DSIZE;
	word_t DOUT;

	logic [15:0] prog [PROG_LEN];
	logic [63:0] exp_store [PROG_LEN];
	int exp_count;
	logic done;
	int errors;
	int stores_seen;
	integer seed = 99401;
	int word_idx;

	thumb_core #(
		.PC_RESET(PC_BASE)
	) u_dut (
		.CLK     (CLK),
		.RESET_N (RESET_N),
		.IREQ    (IREQ),
		.IADDR   (IADDR),
		.IRW     (IRW),
		.INSTR   (INSTR),
		.DREQ    (DREQ),
		.DADDR   (DADDR),
		.DRW     (DRW),
		.DSIZE   (DSIZE),
		.DOUT    (DOUT)
	);

	thumb_checker #(
		.PROG_LEN (PROG_LEN),
		.PC_RESET (PC_BASE)
	) u_check (
		.CLK         (CLK),
		.RESET_N     (RESET_N),
		.IREQ        (IREQ),
		.IADDR       (IADDR),
		.IRW         (IRW),
		.DREQ        (DREQ),
		.DADDR       (DADDR),
		.DRW         (DRW),
		.DSIZE       (DSIZE),
		.DOUT        (DOUT),
		.exp_store   (exp_store),
		.exp_count   (exp_count),
		.done        (done),
		.error_count (errors),
		.store_count (stores_seen)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// --------------------
	// Instruction memory
	// --------------------
	// Zero halfwords past the program decode as no-ops
	function automatic logic [15:0] fetch_half(int idx);
		if (idx >= 0 && idx < PROG_LEN) begin
			return prog[idx];
		end
		return 16'h0000;
	endfunction

	always_comb begin
		word_idx = int'((IADDR - PC_BASE) >> 2);
		INSTR = {fetch_half(2 * word_idx + 1), fetch_half(2 * word_idx)};
	end

	// Random mix of the supported encodings with roughly one store in four
	function automatic void build_program();
		logic [2:0] kind;
		logic [2:0] rd;
		logic [2:0] rn;
		logic [2:0] rm;
		logic [2:0] last_rd;
		logic [7:0] imm8;
		logic [4:0] imm5;
		logic [1:0] sel;
		last_rd = 3'd0;
		for (int i = 0; i < PROG_LEN; i++) begin
			kind = 3'($random(seed));
			rd = 3'($random(seed));
			rn = 3'($random(seed));
			rm = 3'($random(seed));
			imm8 = 8'($random(seed));
			imm5 = 5'($random(seed));
			sel = 2'($random(seed));
			case (kind)
				3'd0, 3'd1: begin
					// Often store the register that was just written
					if (sel[0]) begin
						rd = last_rd;
					end
					prog[i] = {5'b01100, imm5, rn, rd};
				end
				3'd2: prog[i] = {5'b00100, rd, imm8};
				3'd3: prog[i] = {5'b00110, rd, imm8};
				3'd4: prog[i] = {5'b00111, rd, imm8};
				3'd5: prog[i] = {7'b0001100, rm, rn, rd};
				3'd6: prog[i] = {7'b0001101, rm, rn, rd};
				default: begin
					case (sel)
						2'd0:    prog[i] = {10'b0100000000, rm, rd};
						2'd1:    prog[i] = {10'b0100000001, rm, rd};
						default: prog[i] = {10'b0100001100, rm, rd};
					endcase
				end
			endcase
			if (kind > 3'd1) begin
				last_rd = rd;
			end
		end
	endfunction

	// --------------------
	// Reference model
	// --------------------
	function automatic void run_reference();
		word_t regs [8];
		logic [15:0] ir;
		word_t imm;
		word_t addr;
		exp_count = 0;
		for (int r = 0; r < 8; r++) begin
			regs[r] = '0;
		end
		for (int i = 0; i < PROG_LEN; i++) begin
			ir = prog[i];
			imm = {24'd0, ir[7:0]};
			case (ir[15:11])
				5'b00100: regs[ir[10:8]] = imm;
				5'b00110: regs[ir[10:8]] = regs[ir[10:8]] + imm;
				5'b00111: regs[ir[10:8]] = regs[ir[10:8]] - imm;
				5'b00011: begin
					if (ir[10:9] == 2'b00) begin
						regs[ir[2:0]] = regs[ir[5:3]] + regs[ir[8:6]];
					end else if (ir[10:9] == 2'b01) begin
						regs[ir[2:0]] = regs[ir[5:3]] - regs[ir[8:6]];
					end
				end
				5'b01000: begin
					case (ir[10:6])
						5'b00000: regs[ir[2:0]] = regs[ir[2:0]] & regs[ir[5:3]];
						5'b00001: regs[ir[2:0]] = regs[ir[2:0]] ^ regs[ir[5:3]];
						5'b01100: regs[ir[2:0]] = regs[ir[2:0]] | regs[ir[5:3]];
						default: ;
					endcase
				end
				5'b01100: begin
					addr = regs[ir[5:3]] + {25'd0, ir[10:6], 2'b00};
					exp_store[exp_count] = {addr, regs[ir[2:0]]};
					exp_count++;
				end
				default: ;
			endcase
		end
	endfunction

	initial begin
		RESET_N = 1'b0;
		done = 1'b0;
		build_program();
		run_reference();
		repeat (RESET_CYCLES) @(posedge CLK);
		RESET_N <= 1'b1;
		// Wait for the last halfword fetch and let the pipeline drain
		do begin
			@(negedge CLK);
		end while (IADDR < PROG_END);
		repeat (PIPE_LATENCY + 2) @(posedge CLK);
		done <= 1'b1;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		$display("stores expected %0d, seen %0d, errors %0d", exp_count, stores_seen, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		@(posedge RESET_N);
		#((PROG_LEN + 50) * CLK_PERIOD);
		$display("timeout: the program did not finish within %0d cycles", PROG_LEN + 50);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/thumb_checker.sv
`timescale 1ns/10ps
`default_nettype none

module thumb_checker import thumb_pkg::*; #(
	parameter int    PROG_LEN = 200,
	parameter word_t PC_RESET = '0
) (
	input  logic        CLK,
	input  logic        RESET_N,
	input  logic        IREQ,
	input  word_t       IADDR,
	input  logic        IRW,
	input  logic        DREQ,
	input  word_t       DADDR,
	input  logic        DRW,
	input  logic [1:0]  DSIZE,
	input  word_t       DOUT,
	input  logic [63:0] exp_store [PROG_LEN],
	input  int          exp_count,
	input  logic        done,
	output int          error_count,
	output int          store_count
);

	int errors = 0;
	int seen = 0;
	int reset_edges = 0;
	int run_edges = 0;
	logic end_checked = 1'b0;

	assign error_count = errors;
	assign store_count = seen;

	// One DREQ pulse against the next expected (address, data) pair
	task automatic compare_store();
		word_t exp_addr;
		word_t exp_data;
		if (seen >= exp_count) begin
			$display("extra store at %0t ns to address %h, only %0d stores expected",
				$time, DADDR, exp_count);
			errors++;
		end else begin
			exp_addr = exp_store[seen][63:32];
			exp_data = exp_store[seen][31:0];
			if (DADDR !== exp_addr) begin
				$display("error %0t: store %0d address %h, expected %h",
					$time, seen, DADDR, exp_addr);
				errors++;
			end
			if (DOUT !== exp_data) begin
				$display("error %0t: store %0d data %h, expected %h",
					$time, seen, DOUT, exp_data);
				errors++;
			end
			if (DRW !== 1'b1 || DSIZE !== DSIZE_WORD) begin
				$display("error %0t: store %0d DRW %b DSIZE %b, expected 1 and %b",
					$time, seen, DRW, DSIZE, DSIZE_WORD);
				errors++;
			end
		end
		seen++;
	endtask

	always @(posedge CLK) begin
		if (!RESET_N) begin
			reset_edges++;
			run_edges = 0;
			// First edge of reset still shows the power-up value
			if (reset_edges >= 2 && DREQ !== 1'b0) begin
				$display("error %0t: DREQ %b during reset", $time, DREQ);
				errors++;
			end
		end else begin
			if (run_edges == 0 && IADDR !== {PC_RESET[31:2], 2'b00}) begin
				$display("error %0t: first IADDR %h, expected %h",
					$time, IADDR, {PC_RESET[31:2], 2'b00});
				errors++;
			end
			if (run_edges >= 1 && IREQ !== 1'b1) begin
				$display("error %0t: IREQ %b after reset release", $time, IREQ);
				errors++;
			end
			// Instruction port only ever reads
			if (IRW !== 1'b0) begin
				$display("error %0t: IRW %b, expected 0", $time, IRW);
				errors++;
			end
			if (DREQ === 1'b1) begin
				compare_store();
			end else if (DREQ !== 1'b0) begin
				$display("error %0t: DREQ is unknown", $time);
				errors++;
			end
			if (done && !end_checked) begin
				end_checked = 1'b1;
				if (seen < exp_count) begin
					$display("missing stores: only %0d of %0d expected stores appeared",
						seen, exp_count);
					errors++;
				end
			end
			run_edges++;
		end
	end

endmodule

`default_nettype wire

// File: source/thumb_core.sv
`timescale 1ns/10ps
`default_nettype none

module thumb_core import thumb_pkg::*; #(
	parameter word_t PC_RESET = '0
) (
	input  logic       CLK,
	input  logic       RESET_N,
	output logic       IREQ,
	output word_t      IADDR,
	output logic       IRW,
	input  word_t      INSTR,
	output logic       DREQ,
	output word_t      DADDR,
	output logic       DRW,
	output logic [1:0] DSIZE,
	output word_t      DOUT
);

	fetch_pkt_t fetch;
	decode_pkt_t dec;
	exec_pkt_t exe;
	reg_idx_t rd_addr_a;
	reg_idx_t rd_addr_b;
	word_t rd_data_a;
	word_t rd_data_b;

	// --------------------
	// Input side
	// --------------------
	fetch_unit #(
		.PC_RESET(PC_RESET)
	) u_fetch (
		.CLK     (CLK),
		.RESET_N (RESET_N),
		.INSTR   (INSTR),
		.IREQ    (IREQ),
		.IADDR   (IADDR),
		.IRW     (IRW),
		.fetch   (fetch)
	);

	// --------------------
	// Pipeline
	// --------------------
	decode_stage u_decode (
		.CLK       (CLK),
		.RESET_N   (RESET_N),
		.fetch     (fetch),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.dec       (dec)
	);

	// Written back from the execute/memory register
	reg_file u_regs (
		.CLK       (CLK),
		.RESET_N   (RESET_N),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_en     (exe.wr_en),
		.wr_addr   (exe.rd),
		.wr_data   (exe.result)
	);

	execute_stage u_exec (
		.CLK     (CLK),
		.RESET_N (RESET_N),
		.dec     (dec),
		.exe     (exe)
	);

	// --------------------
	// Output side
	// --------------------
	store_port u_store (
		.CLK     (CLK),
		.RESET_N (RESET_N),
		.exe     (exe),
		.DREQ    (DREQ),
		.DADDR   (DADDR),
		.DOUT    (DOUT),
		.DRW     (DRW),
		.DSIZE   (DSIZE)
	);

endmodule

`default_nettype wire

// File: source/store_port.sv
`timescale 1ns/10ps
`default_nettype none

module store_port import thumb_pkg::*; (
	input  logic       CLK,
	input  logic       RESET_N,
	input  exec_pkt_t  exe,
	output logic       DREQ,
	output word_t      DADDR,
	output word_t      DOUT,
	output logic       DRW,
	output logic [1:0] DSIZE
);

	// One-cycle strobe per store
	always_ff @(posedge CLK) begin
		if (!RESET_N) begin
			DREQ <= 1'b0;
			DRW <= 1'b0;
			DSIZE <= 2'b00;
		end else begin
			DREQ <= exe.is_store;
			DRW <= exe.is_store;
			if (exe.is_store) begin
				DSIZE <= DSIZE_WORD;
			end
		end
	end

	// Address and data hold between stores
	always_ff @(posedge CLK) begin
		if (exe.is_store) begin
			DADDR <= exe.st_addr;
			DOUT <= exe.st_data;
		end
	end

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage import thumb_pkg::*; (
	input  logic        CLK,
	input  logic        RESET_N,
	input  decode_pkt_t dec,
	output exec_pkt_t   exe
);

	word_t op_a;
	word_t reg_b;
	word_t op_b;
	word_t alu_out;
	exec_pkt_t nxt;
	logic fwd_a;
	logic fwd_b;

	// --------------------
	// Operand forwarding
	// --------------------
	// Previous instruction still sits in exe and is not yet in the register file
	assign fwd_a = exe.wr_en && (exe.rd == dec.src_a);
	assign fwd_b = exe.wr_en && (exe.rd == dec.src_b);

	assign op_a = fwd_a ? exe.result : dec.a_val;
	assign reg_b = fwd_b ? exe.result : dec.b_val;
	assign op_b = dec.use_imm ? dec.imm : reg_b;

	// --------------------
	// ALU
	// --------------------
	always_comb begin
		case (dec.op)
			ALU_MOV: alu_out = op_b;
			ALU_ADD: alu_out = op_a + op_b;
			ALU_SUB: alu_out = op_a - op_b;
			ALU_AND: alu_out = op_a & op_b;
			ALU_EOR: alu_out = op_a ^ op_b;
			ALU_ORR: alu_out = op_a | op_b;
			default: alu_out = '0;
		endcase
	end

	always_comb begin
		nxt.result = alu_out;
		nxt.rd = dec.rd;
		nxt.wr_en = dec.wr_en;
		nxt.is_store = dec.is_store;
		// Store address is base plus scaled offset and data is the forwarded Rd
		nxt.st_addr = op_a + dec.imm;
		nxt.st_data = reg_b;
	end

	// Execute/memory register
	always_ff @(posedge CLK) begin
		exe <= nxt;
		if (!RESET_N) begin
			exe.wr_en <= 1'b0;
			exe.is_store <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file import thumb_pkg::*; (
	input  logic     CLK,
	input  logic     RESET_N,
	input  reg_idx_t rd_addr_a,
	input  reg_idx_t rd_addr_b,
	output word_t    rd_data_a,
	output word_t    rd_data_b,
	input  logic     wr_en,
	input  reg_idx_t wr_addr,
	input  word_t    wr_data
);

	word_t regs [8];

	always_ff @(posedge CLK) begin
		if (!RESET_N) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Write-through so decode sees a result retiring this cycle
	assign rd_data_a = (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
	assign rd_data_b = (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage import thumb_pkg::*; (
	input  logic        CLK,
	input  logic        RESET_N,
	input  fetch_pkt_t  fetch,
	output reg_idx_t    rd_addr_a,
	output reg_idx_t    rd_addr_b,
	input  word_t       rd_data_a,
	input  word_t       rd_data_b,
	output decode_pkt_t dec
);

	decode_pkt_t nxt;
	logic [15:0] ir;

	assign ir = fetch.instr;

	// --------------------
	// Decoder
	// --------------------
	always_comb begin
		nxt = '0;
		nxt.op = ALU_NOP;
		nxt.rd = ir[2:0];
		nxt.src_a = ir[5:3];
		nxt.src_b = ir[8:6];
		if (fetch.valid) begin
			casez (ir)
				// Immediate forms use Rd as the first source
				16'b00100_???_????????,
				16'b00110_???_????????,
				16'b00111_???_????????: begin
					case (ir[12:11])
						2'b00:   nxt.op = ALU_MOV;
						2'b10:   nxt.op = ALU_ADD;
						default: nxt.op = ALU_SUB;
					endcase
					nxt.rd = ir[10:8];
					nxt.src_a = ir[10:8];
					nxt.src_b = ir[10:8];
					nxt.imm = {24'd0, ir[7:0]};
					nxt.use_imm = 1'b1;
					nxt.wr_en = 1'b1;
				end
				// Three-register add and subtract
				16'b0001100_???_???_???: begin
					nxt.op = ALU_ADD;
					nxt.wr_en = 1'b1;
				end
				16'b0001101_???_???_???: begin
					nxt.op = ALU_SUB;
					nxt.wr_en = 1'b1;
				end
				// Two-register logic ops on Rd and Rm
				16'b0100000000_???_???,
				16'b0100000001_???_???,
				16'b0100001100_???_???: begin
					case (ir[9:6])
						4'b0000: nxt.op = ALU_AND;
						4'b0001: nxt.op = ALU_EOR;
						default: nxt.op = ALU_ORR;
					endcase
					nxt.src_a = ir[2:0];
					nxt.src_b = ir[5:3];
					nxt.wr_en = 1'b1;
				end
				// Word store with base on port a and data on port b
				16'b01100_?????_???_???: begin
					nxt.src_a = ir[5:3];
					nxt.src_b = ir[2:0];
					nxt.imm = {25'd0, ir[10:6], 2'b00};
					nxt.is_store = 1'b1;
				end
				default: ;
			endcase
		end
	end

	assign rd_addr_a = nxt.src_a;
	assign rd_addr_b = nxt.src_b;

	// Decode/execute register
	always_ff @(posedge CLK) begin
		dec <= nxt;
		dec.a_val <= rd_data_a;
		dec.b_val <= rd_data_b;
		if (!RESET_N) begin
			dec.wr_en <= 1'b0;
			dec.is_store <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit import thumb_pkg::*; #(
	parameter word_t PC_RESET = '0
) (
	input  logic       CLK,
	input  logic       RESET_N,
	input  word_t      INSTR,
	output logic       IREQ,
	output word_t      IADDR,
	output logic       IRW,
	output fetch_pkt_t fetch
);

	word_t pc;
	logic [15:0] half;

	// Word address on the port and halfword picked by PC bit 1
	assign IADDR = {pc[31:2], 2'b00};
	assign IRW = 1'b0;
	assign half = pc[1] ? INSTR[31:16] : INSTR[15:0];

	always_ff @(posedge CLK) begin
		fetch.instr <= half;
		if (!RESET_N) begin
			pc <= PC_RESET;
			IREQ <= 1'b0;
			fetch.valid <= 1'b0;
		end else begin
			IREQ <= 1'b1;
			// Only a requested halfword is a real instruction
			fetch.valid <= IREQ;
			if (IREQ) begin
				pc <= pc + 32'd2;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/thumb_pkg.sv
`default_nettype none

package thumb_pkg;

	typedef logic [31:0] word_t;
	typedef logic [2:0] reg_idx_t;

	// Execute operations
	typedef enum logic [2:0] {
		ALU_MOV = 3'd0,
		ALU_ADD = 3'd1,
		ALU_SUB = 3'd2,
		ALU_AND = 3'd3,
		ALU_EOR = 3'd4,
		ALU_ORR = 3'd5,
		ALU_NOP = 3'd7
	} alu_op_t;

	// Data port size code for a 32-bit store
	localparam logic [1:0] DSIZE_WORD = 2'b10;

	// --------------------
	// Stage payloads
	// --------------------
	typedef struct packed {
		logic [15:0] instr;
		logic        valid;
	} fetch_pkt_t;

	typedef struct packed {
		alu_op_t  op;
		reg_idx_t rd;
		reg_idx_t src_a;
		reg_idx_t src_b;
		word_t    imm;
		logic     use_imm;
		word_t    a_val;
		word_t    b_val;
		logic     wr_en;
		logic     is_store;
	} decode_pkt_t;

	typedef struct packed {
		word_t    result;
		reg_idx_t rd;
		logic     wr_en;
		logic     is_store;
		word_t    st_addr;
		word_t    st_data;
	} exec_pkt_t;

endpackage

`default_nettype wire
